/* list.f */
+incdir+logic
+incdir+test
logic/audio_pkg.sv
logic/audio_recorder.sv
logic/audio_player.sv
logic/audio_dsp.sv
logic/recorder_control.sv
logic/audio_top.sv
test/audio_tb.sv

/* logic/audio_dsp.sv */
module audio_dsp (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  logic               i_en,
	input  logic               i_restart,
	input  audio_pkg::speed_t  i_speed,
	input  logic               i_fast,
	input  logic               i_slow_0,
	input  logic               i_slow_1,
	input  audio_pkg::addr_t   i_length,
	input  audio_pkg::sample_t i_rdata,
	input  logic               i_frame_done,
	output audio_pkg::addr_t   o_addr,
	output audio_pkg::sample_t o_sample,
	output logic               o_valid,
	output logic               o_done
);
	import audio_pkg::*;

	localparam int SW = $bits(sample_t);

	typedef enum logic [2:0] {
		D_IDLE,
		D_FETCH_A,
		D_FETCH_B,
		D_CALC,
		D_WAIT
	} dsp_state_t;

	dsp_state_t          state;
	addr_t               addr;
	addr_t               addr_b;
	addr_t               addr_next;
	speed_t              speed;
	speed_t              phase;
	speed_t              phase_next;
	logic                interp_mode;
	sample_t             word_a;
	sample_t             word_b;
	sample_t             sample;
	logic                loaded;
	logic                done;
	logic signed [SW:0]   diff;
	logic signed [SW+4:0] prod;
	logic signed [SW+4:0] quot;
	logic signed [SW+4:0] interp;

	// fast wins over repeat, repeat over interpolation
	assign interp_mode = i_slow_1 && !i_fast && !i_slow_0;
	assign addr_b      = addr + addr_t'(1);

	always_comb begin
		speed  = speed_norm(i_speed);
		// a + (b - a) * k / speed, truncating toward zero
		diff   = $signed({word_b[SW-1], word_b}) - $signed({word_a[SW-1], word_a});
		prod   = diff * $signed({1'b0, phase});
		quot   = prod / $signed({1'b0, speed});
		interp = $signed({{5{word_a[SW-1]}}, word_a}) + quot;

		addr_next  = addr_b;
		phase_next = '0;
		if (i_fast) begin
			addr_next = addr + addr_t'(speed);
		end else if (i_slow_0 || i_slow_1) begin
			// stay on this word until it was used speed times
			if (phase < speed - speed_t'(1)) begin
				addr_next  = addr;
				phase_next = phase + speed_t'(1);
			end
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state  <= D_IDLE;
			addr   <= '0;
			phase  <= '0;
			loaded <= 1'b0;
			done   <= 1'b0;
		end else begin
			done <= 1'b0;
			if (i_restart) begin
				state  <= D_FETCH_A;
				addr   <= '0;
				phase  <= '0;
				loaded <= 1'b0;
			end else begin
				case (state)
					D_IDLE: state <= D_IDLE;
					D_FETCH_A: begin
						if (addr >= i_length) begin
							state  <= D_IDLE;
							loaded <= 1'b0;
							done   <= 1'b1;
						end else begin
							state <= interp_mode ? D_FETCH_B : D_CALC;
						end
					end
					D_FETCH_B: state <= D_CALC;
					D_CALC: begin
						state  <= D_WAIT;
						loaded <= 1'b1;
					end
					// hold the sample until the player has sent it
					D_WAIT: begin
						if (i_en && i_frame_done) begin
							addr  <= addr_next;
							phase <= phase_next;
							state <= D_FETCH_A;
						end
					end
					default: state <= D_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (state == D_FETCH_A)
			word_a <= i_rdata;
		// past the end the last word is its own neighbour
		if (state == D_FETCH_B)
			word_b <= (addr_b < i_length) ? i_rdata : word_a;
		if (state == D_CALC)
			sample <= interp_mode ? interp[SW-1:0] : word_a;
	end

	assign o_addr   = (state == D_FETCH_B) ? addr_b : addr;
	assign o_sample = sample;
	assign o_valid  = loaded && i_en;
	assign o_done   = done;

endmodule

/* logic/audio_pkg.sv */
`include "audio_settings.svh"

package audio_pkg;

	typedef logic [`AUD_SAMPLE_W-1:0] sample_t;
	typedef logic [`AUD_ADDR_W-1:0]   addr_t;
	typedef logic [3:0]               speed_t;
	typedef logic [5:0]               time_t;

	// top level mode machine
	typedef enum logic [2:0] {
		ST_STOP,
		ST_RECD,
		ST_RECD_PAUSE,
		ST_PLAY,
		ST_PLAY_PAUSE
	} ctrl_state_t;

	// speed factor as used by the datapath, 0 counts as 1
	function automatic speed_t speed_norm(input speed_t s);
		speed_t r;
		r = s;
		if (s == '0)
			r = speed_t'(1);
		else if (s > speed_t'(`AUD_MAX_SPEED))
			r = speed_t'(`AUD_MAX_SPEED);
		return r;
	endfunction

endpackage

/* logic/audio_player.sv */
module audio_player (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  logic               i_en,
	input  logic               i_bclk,
	input  logic               i_daclrck,
	input  audio_pkg::sample_t i_sample,
	output logic               o_dacdat,
	output logic               o_frame_done
);
	import audio_pkg::*;

	localparam int SW    = $bits(sample_t);
	localparam int CNT_W = $clog2(SW);

	typedef enum logic [1:0] {
		P_IDLE,
		P_SKIP,
		P_SHIFT
	} play_state_t;

	play_state_t      state;
	logic [1:0]       sync_meta;
	logic [1:0]       sync_q;
	logic             bclk_prev;
	logic             lrck_prev;
	logic             bclk_fall;
	logic             lrck_fall;
	logic [CNT_W-1:0] bit_cnt;
	sample_t          shift;
	logic             dacdat;
	logic             frame_done;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sync_meta <= '0;
			sync_q    <= '0;
			bclk_prev <= 1'b0;
			lrck_prev <= 1'b0;
		end else begin
			sync_meta <= {i_daclrck, i_bclk};
			sync_q    <= sync_meta;
			bclk_prev <= sync_q[0];
			lrck_prev <= sync_q[1];
		end
	end

	assign bclk_fall = ~sync_q[0] & bclk_prev;
	assign lrck_fall = ~sync_q[1] & lrck_prev;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state      <= P_IDLE;
			bit_cnt    <= '0;
			dacdat     <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (!i_en) begin
				state  <= P_IDLE;
				dacdat <= 1'b0;
			end else begin
				case (state)
					// right channel slot is silent
					P_IDLE: begin
						if (bclk_fall)
							dacdat <= 1'b0;
						if (lrck_fall) begin
							bit_cnt <= '0;
							// a bclk fall together with lrck is the skipped one
							state   <= bclk_fall ? P_SHIFT : P_SKIP;
						end
					end
					P_SKIP: begin
						if (bclk_fall)
							state <= P_SHIFT;
					end
					P_SHIFT: begin
						if (bclk_fall) begin
							dacdat  <= shift[SW-1];
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == CNT_W'(SW - 1)) begin
								state      <= P_IDLE;
								frame_done <= 1'b1;
							end
						end
					end
					default: state <= P_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (state == P_IDLE && lrck_fall)
			shift <= i_sample;
		else if (state == P_SHIFT && bclk_fall)
			shift <= shift << 1;
	end

	assign o_dacdat     = dacdat;
	assign o_frame_done = frame_done;

endmodule

/* logic/audio_recorder.sv */
`include "audio_settings.svh"

module audio_recorder (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  logic               i_en,
	input  logic               i_clear,
	input  logic               i_bclk,
	input  logic               i_adclrck,
	input  logic               i_adcdat,
	output audio_pkg::addr_t   o_addr,
	output audio_pkg::sample_t o_wdata,
	output logic               o_we,
	output logic               o_full
);
	import audio_pkg::*;

	localparam int SW    = $bits(sample_t);
	localparam int CNT_W = $clog2(SW);

	typedef enum logic [1:0] {
		R_IDLE,
		R_SKIP,
		R_SHIFT,
		R_WRITE
	} rec_state_t;

	rec_state_t       state;
	// bit 0 bclk, bit 1 lrck, bit 2 data
	logic [2:0]       sync_meta;
	logic [2:0]       sync_q;
	logic             bclk_prev;
	logic             lrck_prev;
	logic             bclk_rise;
	logic             lrck_fall;
	logic [CNT_W-1:0] bit_cnt;
	addr_t            addr;
	sample_t          shift;
	logic             full;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sync_meta <= '0;
			sync_q    <= '0;
			bclk_prev <= 1'b0;
			lrck_prev <= 1'b0;
		end else begin
			sync_meta <= {i_adcdat, i_adclrck, i_bclk};
			sync_q    <= sync_meta;
			bclk_prev <= sync_q[0];
			lrck_prev <= sync_q[1];
		end
	end

	assign bclk_rise = sync_q[0] & ~bclk_prev;
	assign lrck_fall = ~sync_q[1] & lrck_prev;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state   <= R_IDLE;
			bit_cnt <= '0;
			addr    <= '0;
			full    <= 1'b0;
		end else if (i_clear) begin
			state   <= R_IDLE;
			bit_cnt <= '0;
			addr    <= '0;
			full    <= 1'b0;
		end else if (!i_en) begin
			// a half captured word is dropped
			state <= R_IDLE;
		end else begin
			case (state)
				R_IDLE: begin
					if (lrck_fall && !full)
						state <= R_SKIP;
				end
				// i2s delay bit
				R_SKIP: begin
					if (bclk_rise) begin
						state   <= R_SHIFT;
						bit_cnt <= '0;
					end
				end
				R_SHIFT: begin
					if (bclk_rise) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == CNT_W'(SW - 1))
							state <= R_WRITE;
					end
				end
				R_WRITE: begin
					state <= R_IDLE;
					addr  <= addr + 1'b1;
					if (addr == addr_t'(`AUD_MAX_ADDR))
						full <= 1'b1;
				end
				default: state <= R_IDLE;
			endcase
		end
	end

	// msb first
	always_ff @(posedge i_clk) begin
		if (state == R_SHIFT && bclk_rise)
			shift <= {shift[SW-2:0], sync_q[2]};
	end

	assign o_we    = (state == R_WRITE) && i_en;
	assign o_addr  = addr;
	assign o_wdata = shift;
	assign o_full  = full;

endmodule

/* logic/audio_settings.svh */
`ifndef AUDIO_SETTINGS_SVH
`define AUDIO_SETTINGS_SVH

// sram word address width
`define AUD_ADDR_W 20

// one audio sample
`define AUD_SAMPLE_W 16

// samples per displayed time tick
// the board would use the sample rate here
`define AUD_SAMPLES_PER_TICK 8

// last writable sram address, recording stops after it
`define AUD_MAX_ADDR 63

// upper bound of the speed factor
`define AUD_MAX_SPEED 8

`endif

/* logic/audio_top.sv */
module audio_top (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  logic                   i_key_0,
	input  logic                   i_key_1,
	input  logic                   i_key_2,
	input  audio_pkg::speed_t      i_speed,
	input  logic                   i_fast,
	input  logic                   i_slow_0,
	input  logic                   i_slow_1,
	input  logic                   i_aud_bclk,
	input  logic                   i_aud_adclrck,
	input  logic                   i_aud_adcdat,
	input  logic                   i_aud_daclrck,
	input  audio_pkg::sample_t     i_sram_rdata,
	output logic                   o_aud_dacdat,
	output audio_pkg::addr_t       o_sram_addr,
	output audio_pkg::sample_t     o_sram_wdata,
	output logic                   o_sram_we_n,
	output audio_pkg::ctrl_state_t o_state,
	output audio_pkg::time_t       o_record_time,
	output audio_pkg::time_t       o_play_time
);
	import audio_pkg::*;

	logic    rec_en;
	logic    rec_clear;
	logic    rec_we;
	logic    rec_full;
	addr_t   rec_addr;
	logic    play_en;
	logic    play_restart;
	addr_t   dsp_addr;
	logic    dsp_done;
	sample_t dac_sample;
	logic    dac_valid;
	logic    frame_done;

	// key 0 record, key 1 play, key 2 stop
	recorder_control recorder_control_inst (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_key_rec      (i_key_0),
		.i_key_play     (i_key_1),
		.i_key_stop     (i_key_2),
		.i_speed        (i_speed),
		.i_rec_full     (rec_full),
		.i_dsp_done     (dsp_done),
		.i_rec_addr     (rec_addr),
		.i_dsp_addr     (dsp_addr),
		.i_rec_we       (rec_we),
		.i_rec_tick     (rec_we),
		.i_play_tick    (frame_done),
		.o_rec_en       (rec_en),
		.o_rec_clear    (rec_clear),
		.o_play_en      (play_en),
		.o_play_restart (play_restart),
		.o_sram_addr    (o_sram_addr),
		.o_sram_we_n    (o_sram_we_n),
		.o_state        (o_state),
		.o_record_time  (o_record_time),
		.o_play_time    (o_play_time)
	);

	audio_recorder audio_recorder_inst (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_en      (rec_en),
		.i_clear   (rec_clear),
		.i_bclk    (i_aud_bclk),
		.i_adclrck (i_aud_adclrck),
		.i_adcdat  (i_aud_adcdat),
		.o_addr    (rec_addr),
		.o_wdata   (o_sram_wdata),
		.o_we      (rec_we),
		.o_full    (rec_full)
	);

	// recorded length is the recorder's next write address
	audio_dsp audio_dsp_inst (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_en         (play_en),
		.i_restart    (play_restart),
		.i_speed      (i_speed),
		.i_fast       (i_fast),
		.i_slow_0     (i_slow_0),
		.i_slow_1     (i_slow_1),
		.i_length     (rec_addr),
		.i_rdata      (i_sram_rdata),
		.i_frame_done (frame_done),
		.o_addr       (dsp_addr),
		.o_sample     (dac_sample),
		.o_valid      (dac_valid),
		.o_done       (dsp_done)
	);

	audio_player audio_player_inst (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_en         (dac_valid),
		.i_bclk       (i_aud_bclk),
		.i_daclrck    (i_aud_daclrck),
		.i_sample     (dac_sample),
		.o_dacdat     (o_aud_dacdat),
		.o_frame_done (frame_done)
	);

endmodule

/* logic/recorder_control.sv */
`include "audio_settings.svh"

module recorder_control (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  logic                   i_key_rec,
	input  logic                   i_key_play,
	input  logic                   i_key_stop,
	input  audio_pkg::speed_t      i_speed,
	input  logic                   i_rec_full,
	input  logic                   i_dsp_done,
	input  audio_pkg::addr_t       i_rec_addr,
	input  audio_pkg::addr_t       i_dsp_addr,
	input  logic                   i_rec_we,
	input  logic                   i_rec_tick,
	input  logic                   i_play_tick,
	output logic                   o_rec_en,
	output logic                   o_rec_clear,
	output logic                   o_play_en,
	output logic                   o_play_restart,
	output audio_pkg::addr_t       o_sram_addr,
	output logic                   o_sram_we_n,
	output audio_pkg::ctrl_state_t o_state,
	output audio_pkg::time_t       o_record_time,
	output audio_pkg::time_t       o_play_time
);
	import audio_pkg::*;

	localparam int TICK_N = `AUD_SAMPLES_PER_TICK;
	localparam int TICK_W = $clog2(TICK_N + 1);

	ctrl_state_t       state;
	ctrl_state_t       state_nxt;
	// key order is rec, play, stop
	logic [2:0]        key_meta;
	logic [2:0]        key_sync;
	logic [2:0]        key_prev;
	logic [2:0]        key_hit;
	logic              new_rec;
	logic              new_play;
	logic              rec_clear;
	logic              play_restart;
	logic [TICK_W-1:0] rec_cnt;
	logic [TICK_W-1:0] play_cnt;
	time_t             record_time;
	time_t             play_time;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			key_meta <= '0;
			key_sync <= '0;
			key_prev <= '0;
			key_hit  <= '0;
		end else begin
			key_meta <= {i_key_stop, i_key_play, i_key_rec};
			key_sync <= key_meta;
			key_prev <= key_sync;
			key_hit  <= key_sync & ~key_prev;
		end
	end

	always_comb begin
		state_nxt = state;
		new_rec   = 1'b0;
		new_play  = 1'b0;
		case (state)
			ST_STOP: begin
				if (key_hit[0]) begin
					state_nxt = ST_RECD;
					new_rec   = 1'b1;
				end else if (key_hit[1]) begin
					state_nxt = ST_PLAY;
					new_play  = 1'b1;
				end
			end
			// full is stale while the clear is still in flight
			ST_RECD: begin
				if (i_rec_full && !rec_clear)
					state_nxt = ST_STOP;
				else if (key_hit[0])
					state_nxt = ST_RECD_PAUSE;
			end
			ST_RECD_PAUSE: begin
				if (key_hit[0])
					state_nxt = ST_RECD;
				else if (key_hit[2])
					state_nxt = ST_STOP;
			end
			ST_PLAY: begin
				if (i_dsp_done)
					state_nxt = ST_STOP;
				else if (key_hit[1])
					state_nxt = ST_PLAY_PAUSE;
			end
			// last word may finish just as pause is taken
			ST_PLAY_PAUSE: begin
				if (i_dsp_done || key_hit[2])
					state_nxt = ST_STOP;
				else if (key_hit[1])
					state_nxt = ST_PLAY;
			end
			default: state_nxt = ST_STOP;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state        <= ST_STOP;
			rec_clear    <= 1'b0;
			play_restart <= 1'b0;
		end else begin
			state        <= state_nxt;
			rec_clear    <= new_rec;
			play_restart <= new_play;
		end
	end

	// time display counters
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rec_cnt     <= '0;
			record_time <= '0;
			play_cnt    <= '0;
			play_time   <= '0;
		end else begin
			if (new_rec) begin
				rec_cnt     <= '0;
				record_time <= '0;
			end else if (state == ST_RECD && i_rec_tick) begin
				if (rec_cnt == TICK_W'(TICK_N - 1)) begin
					rec_cnt     <= '0;
					record_time <= record_time + time_t'(1);
				end else begin
					rec_cnt <= rec_cnt + 1'b1;
				end
			end

			if (new_play) begin
				play_cnt  <= '0;
				play_time <= '0;
			end else if (state == ST_PLAY && i_play_tick) begin
				if (play_cnt == TICK_W'(TICK_N - 1)) begin
					play_cnt  <= '0;
					play_time <= play_time + time_t'(speed_norm(i_speed));
				end else begin
					play_cnt <= play_cnt + 1'b1;
				end
			end
		end
	end

	// recorder owns the sram only while recording
	assign o_sram_addr    = (state == ST_RECD) ? i_rec_addr : i_dsp_addr;
	assign o_sram_we_n    = ~((state == ST_RECD) && i_rec_we);

	assign o_rec_en       = (state == ST_RECD);
	assign o_play_en      = (state == ST_PLAY);
	assign o_rec_clear    = rec_clear;
	assign o_play_restart = play_restart;
	assign o_state        = state;
	assign o_record_time  = record_time;
	assign o_play_time    = play_time;

endmodule

/* run_sim.sh */
#!/bin/sh
# builds the recorder testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --top-module audio_tb -f list.f -o audio_sim > build.log 2>&1 &&
	./obj_dir/audio_sim > sim.log 2>&1

grep -q "All tests passed!" sim.log || { echo "simulation failed, see build.log and sim.log"; exit 1; }
echo "simulation passed"
exit 0

/* test/audio_tb_tasks.svh */
`ifndef AUDIO_TB_TASKS_SVH
`define AUDIO_TB_TASKS_SVH

// expected playback from the recorded words
// mode 0 normal, 1 fast, 2 repeat, 3 interpolate
function automatic void ref_playback(input int speed, input int mode);
	int len;
	int s;
	int i;
	int a;
	int b;
	exp_play.delete();
	len = rec_words.size();
	s = (speed == 0) ? 1 : speed;
	i = 0;
	while (i < len) begin
		a = $signed(rec_words[i]);
		if (mode == 1) begin
			exp_play.push_back(rec_words[i]);
			i += s;
		end else if (mode == 2 || mode == 3) begin
			// last word has itself as neighbour
			b = (i + 1 < len) ? $signed(rec_words[i + 1]) : a;
			for (int k = 0; k < s; k++) begin
				if (mode == 2)
					exp_play.push_back(rec_words[i]);
				else
					exp_play.push_back(sample_t'(a + (b - a) * k / s));
			end
			i++;
		end else begin
			exp_play.push_back(rec_words[i]);
			i++;
		end
	end
endfunction

task automatic check_sample(input string name, input sample_t got, input sample_t exp);
	if (got !== exp) begin
		$display("[ERROR] %0t %s: expected %h, got %h", $time, name, exp, got);
		errors++;
	end
endtask

task automatic check_state(input ctrl_state_t got, input ctrl_state_t exp);
	if (got !== exp) begin
		$display("[ERROR] %0t o_state: expected %s, got %s", $time, exp.name(), got.name());
		errors++;
	end
endtask

task automatic check_time(input string name, input time_t got, input time_t exp);
	if (got !== exp) begin
		$display("[ERROR] %0t %s: expected %0d, got %0d", $time, name, exp, got);
		errors++;
	end
endtask

task automatic check_count(input string name, input int got, input int exp);
	if (got != exp) begin
		$display("[ERROR] %0t %s: expected %0d, got %0d", $time, name, exp, got);
		errors++;
	end
endtask

task automatic start_test(input string name);
	test_name = name;
	test_err0 = errors;
	tests++;
endtask

task automatic end_test();
	if (errors == test_err0) begin
		$display("test %0d %s: ok", tests, test_name);
	end else begin
		$display("test %0d %s: failed", tests, test_name);
		tests_failed++;
	end
endtask

task automatic timed_out(input string what);
	$display("timeout: %s did not happen in time, remaining waits skipped", what);
	errors++;
	aborted = 1'b1;
endtask

task automatic wait_state(input ctrl_state_t st, input int limit, input string what);
	int n;
	n = 0;
	while (!aborted && o_state != st) begin
		@(negedge i_clk);
		n++;
		if (n > limit)
			timed_out(what);
	end
endtask

task automatic wait_writes(input int target, input int limit);
	int n;
	n = 0;
	while (!aborted && write_cnt < target) begin
		@(negedge i_clk);
		n++;
		if (n > limit)
			timed_out("sram writes");
	end
endtask

task automatic wait_words(input int target, input int limit);
	int n;
	n = 0;
	while (!aborted && word_cnt < target) begin
		@(negedge i_clk);
		n++;
		if (n > limit)
			timed_out("dac words");
	end
endtask

task automatic wait_collector(input int limit);
	int n;
	n = 0;
	while (!aborted && word_pending) begin
		@(negedge i_clk);
		n++;
		if (n > limit)
			timed_out("last dac word");
	end
endtask

// slot start as seen on the falling clock edge
task automatic wait_slot(input logic [4:0] s, input int limit);
	int n;
	n = 0;
	@(negedge i_clk);
	while (!aborted && !(slot == s && div == 3'd0)) begin
		@(negedge i_clk);
		n++;
		if (n > limit)
			timed_out("codec slot");
	end
endtask

task automatic wait_frames(input int count);
	for (int i = 0; i < count; i++)
		wait_slot(5'd0, 400);
endtask

// keys go down in the right half away from frame starts
task automatic press_key(input int k);
	wait_slot(5'd20, 400);
	case (k)
		0: i_key_0 = 1'b1;
		1: i_key_1 = 1'b1;
		default: i_key_2 = 1'b1;
	endcase
	repeat (4) @(negedge i_clk);
	i_key_0 = 1'b0;
	i_key_1 = 1'b0;
	i_key_2 = 1'b0;
endtask

// start a new recording and pause it after n writes
task automatic record_words(input int n);
	int w0;
	exp_rec.delete();
	w0 = write_cnt;
	press_key(0);
	rec_on = 1'b1;
	wait_state(ST_RECD, 50, "record start");
	wait_writes(w0 + n, n * 300 + 1000);
	press_key(0);
	rec_on = 1'b0;
	wait_state(ST_RECD_PAUSE, 50, "record pause");
	check_count("sram writes", write_cnt - w0, n);
endtask

task automatic run_play(input int speed, input int mode);
	i_speed = speed_t'(speed);
	i_fast = (mode == 1);
	i_slow_0 = (mode == 2);
	i_slow_1 = (mode == 3);
	ref_playback(speed, mode);
	word_base = word_cnt;
	compare_on = 1'b1;
	press_key(1);
	wait_state(ST_PLAY, 50, "play start");
	wait_state(ST_STOP, exp_play.size() * 300 + 2000, "end of playback");
	wait_collector(400);
	compare_on = 1'b0;
	check_count("dac words", word_cnt - word_base, exp_play.size());
	check_time("o_play_time", o_play_time,
		time_t'((exp_play.size() / `AUD_SAMPLES_PER_TICK) * speed));
endtask

task automatic pause_checks();
	int w1;
	record_words(10);
	w1 = write_cnt;
	wait_frames(3);
	check_count("sram writes in pause", write_cnt - w1, 0);
	press_key(2);
	wait_state(ST_STOP, 50, "stop from record pause");

	i_speed = speed_t'(1);
	i_fast = 1'b0;
	i_slow_0 = 1'b0;
	i_slow_1 = 1'b0;
	press_key(1);
	wait_state(ST_PLAY, 50, "play start");
	wait_words(word_cnt + 2, 2000);
	press_key(1);
	wait_state(ST_PLAY_PAUSE, 50, "play pause");
	wait_collector(400);
	w1 = word_cnt;
	wait_frames(3);
	check_count("dac words in pause", word_cnt - w1, 0);
	press_key(2);
	wait_state(ST_STOP, 50, "stop from play pause");
endtask

task automatic full_record();
	int w0;
	exp_rec.delete();
	w0 = write_cnt;
	press_key(0);
	rec_on = 1'b1;
	wait_state(ST_RECD, 50, "record start");
	wait_state(ST_STOP, 25000, "stop on full memory");
	rec_on = 1'b0;
	check_count("sram writes", write_cnt - w0, `AUD_MAX_ADDR + 1);
	if (exp_rec.size() < 64) begin
		$display("only %0d ADC words were captured, 64 expected", exp_rec.size());
		errors++;
	end
	for (int i = 0; i < 64 && i < exp_rec.size(); i++)
		check_sample("sram word", mem[i], exp_rec[i]);
endtask

`endif

/* test/audio_tb.sv */
`include "audio_settings.svh"

module audio_tb;
	import audio_pkg::*;

	localparam int SW = `AUD_SAMPLE_W;

	logic        i_clk = 1'b0;
	logic        i_rst_n = 1'b0;
	logic        i_key_0 = 1'b0;
	logic        i_key_1 = 1'b0;
	logic        i_key_2 = 1'b0;
	speed_t      i_speed = speed_t'(1);
	logic        i_fast = 1'b0;
	logic        i_slow_0 = 1'b0;
	logic        i_slow_1 = 1'b0;
	logic        aud_bclk = 1'b1;
	logic        aud_lrck = 1'b1;
	logic        aud_adcdat = 1'b0;
	sample_t     sram_rdata;
	logic        o_aud_dacdat;
	addr_t       o_sram_addr;
	sample_t     o_sram_wdata;
	logic        o_sram_we_n;
	ctrl_state_t o_state;
	time_t       o_record_time;
	time_t       o_play_time;

	// codec model state
	logic [2:0]  div = 3'd0;
	logic [4:0]  slot = 5'd31;
	logic [4:0]  nslot;
	sample_t     adc_word = '0;
	sample_t     adc_bits;
	sample_t     new_word;
	sample_t     dac_shift = '0;
	sample_t     dac_word;
	logic        word_pending = 1'b0;
	int          word_cnt = 0;
	int          word_base = 0;
	logic        rec_on = 1'b0;
	logic        compare_on = 1'b0;

	sample_t     mem [0:63];
	int          write_cnt = 0;
	sample_t     exp_rec[$];
	sample_t     rec_words[$];
	sample_t     exp_play[$];

	int          errors = 0;
	int          tests = 0;
	int          tests_failed = 0;
	int          test_err0 = 0;
	string       test_name;
	logic        aborted = 1'b0;

	`include "audio_tb_tasks.svh"

	always #20 i_clk = ~i_clk;

	audio_top audio_top_inst (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_key_0       (i_key_0),
		.i_key_1       (i_key_1),
		.i_key_2       (i_key_2),
		.i_speed       (i_speed),
		.i_fast        (i_fast),
		.i_slow_0      (i_slow_0),
		.i_slow_1      (i_slow_1),
		.i_aud_bclk    (aud_bclk),
		.i_aud_adclrck (aud_lrck),
		.i_aud_adcdat  (aud_adcdat),
		.i_aud_daclrck (aud_lrck),
		.i_sram_rdata  (sram_rdata),
		.o_aud_dacdat  (o_aud_dacdat),
		.o_sram_addr   (o_sram_addr),
		.o_sram_wdata  (o_sram_wdata),
		.o_sram_we_n   (o_sram_we_n),
		.o_state       (o_state),
		.o_record_time (o_record_time),
		.o_play_time   (o_play_time)
	);

	// async sram model with a preset pattern
	initial begin
		for (int i = 0; i < 64; i++)
			mem[i] = sample_t'((i * 16'h0301) ^ 16'h5a5a);
	end

	assign sram_rdata = mem[o_sram_addr[5:0]];

	always @(posedge i_clk) begin
		if (!o_sram_we_n) begin
			mem[o_sram_addr[5:0]] <= o_sram_wdata;
			write_cnt <= write_cnt + 1;
		end
	end

	// codec model with bclk at clk/8 and 32 slots per frame
	// lrck is low for the left half
	always @(negedge i_clk) begin
		div <= div + 3'd1;
		if (div == 3'd7) begin
			nslot = slot + 5'd1;
			slot <= nslot;
			aud_bclk <= 1'b0;
			aud_lrck <= nslot[4];
			if (nslot == 5'd0) begin
				new_word = sample_t'($urandom);
				adc_word <= new_word;
				if (rec_on)
					exp_rec.push_back(new_word);
			end
			// data after the one slot i2s delay
			adc_bits = adc_word << (nslot - 5'd1);
			aud_adcdat <= (nslot >= 5'd1 && nslot <= 5'd16) ? adc_bits[SW-1] : 1'b0;
			// dac bit of the previous slot
			if (nslot >= 5'd2 && nslot <= 5'd17)
				dac_shift <= {dac_shift[SW-2:0], o_aud_dacdat};
			if (nslot == 5'd17 && word_pending) begin
				dac_word = {dac_shift[SW-2:0], o_aud_dacdat};
				word_pending <= 1'b0;
				if (compare_on) begin
					if (word_cnt - word_base < exp_play.size()) begin
						check_sample("o_aud_dacdat", dac_word, exp_play[word_cnt - word_base]);
					end else begin
						$display("extra DAC word %h at time %0t beyond the expected sequence",
							dac_word, $time);
						errors++;
					end
				end
				word_cnt <= word_cnt + 1;
			end
		end else if (div == 3'd3) begin
			aud_bclk <= 1'b1;
		end
		if (audio_top_inst.frame_done)
			word_pending <= 1'b1;
	end

	initial begin
		void'($urandom(50));
		i_rst_n = 1'b0;
		repeat (2) @(negedge i_clk);
		i_rst_n = 1'b1;

		start_test("record 20 samples");
		check_state(o_state, ST_STOP);
		check_time("o_record_time", o_record_time, time_t'(0));
		record_words(20);
		press_key(2);
		wait_state(ST_STOP, 50, "stop after record");
		check_count("captured words", exp_rec.size(), 20);
		for (int i = 0; i < 20 && i < exp_rec.size(); i++)
			check_sample("sram word", mem[i], exp_rec[i]);
		check_time("o_record_time", o_record_time, time_t'(20 / `AUD_SAMPLES_PER_TICK));
		rec_words = exp_rec;
		end_test();

		start_test("normal playback speed 1");
		run_play(1, 0);
		end_test();

		start_test("fast playback speed 2");
		run_play(2, 1);
		end_test();

		start_test("repeat and interpolate speed 2");
		run_play(2, 2);
		run_play(2, 3);
		end_test();

		start_test("pause and stop");
		pause_checks();
		end_test();

		start_test("record until full");
		full_record();
		end_test();

		$display("tests %0d, failed %0d, errors %0d", tests, tests_failed, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule
